// ==== hdl/aux_payload.sv ====
`timescale 1ns/1ns
`default_nettype none

module aux_payload import udp_tx_pkg::*; (
	input  wire            fifo_clk,
	input  wire            sys_rst,
	input  wire sample_t   fifo_rdata,
	input  wire fifo_cnt_t fifo_count,
	output logic           fifo_rd,
	output logic           req,
	input  wire            ack,
	output pkt_kind_t      kind,
	output len_t           payload_len,
	output octet_t         pay_byte,
	input  wire            pay_take
);

	// Byte within the current sample
	logic [1:0] bsel;

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			req  <= 1'b0;
			bsel <= 2'd0;
		end else if (req && ack) begin
			req  <= 1'b0;
			bsel <= 2'd0;
		end else begin
			if (!req && !ack && fifo_count >= fifo_cnt_t'(AUX_SAMPLES)) begin
				req <= 1'b1;
			end
			if (pay_take) begin
				bsel <= (bsel == 2'd2) ? 2'd0 : bsel + 2'd1;
			end
		end
	end

	// High byte first
	always_comb begin
		case (bsel)
			2'd0:    pay_byte = fifo_rdata[23:16];
			2'd1:    pay_byte = fifo_rdata[15:8];
			default: pay_byte = fifo_rdata[7:0];
		endcase
	end

	assign fifo_rd     = pay_take && (bsel == 2'd2);
	assign kind        = KIND_AUX;
	assign payload_len = AUX_LEN;

endmodule

`default_nettype wire

// ==== hdl/eth_crc32.sv ====
`timescale 1ns/1ns
`default_nettype none

module eth_crc32 import udp_tx_pkg::*; (
	input  wire         fifo_clk,
	input  wire         sys_rst,
	input  wire         init,
	input  wire         en,
	input  wire octet_t data,
	output crc_t        crc
);

	crc_t crc_reg;

	// One byte, LSB first
	function automatic crc_t crc_next(input crc_t c, input octet_t d);
		crc_t r;
		r = c ^ {24'd0, d};
		for (int i = 0; i < 8; i++) begin
			r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
		end
		return r;
	endfunction

	always_ff @(posedge fifo_clk) begin
		if (sys_rst || init) begin
			crc_reg <= '1;
		end else if (en) begin
			crc_reg <= crc_next(crc_reg, data);
		end
	end

	// Inverted and byte swapped so bits 31:24 go on the wire first
	assign crc = ~{crc_reg[7:0], crc_reg[15:8], crc_reg[23:16], crc_reg[31:24]};

endmodule

`default_nettype wire

// ==== hdl/gmii_framer.sv ====
`timescale 1ns/1ns
`default_nettype none

module gmii_framer import udp_tx_pkg::*; (
	input  wire            fifo_clk,
	input  wire            sys_rst,
	input  wire            frame_req,
	output logic           frame_ack,
	input  wire pkt_kind_t frame_kind,
	input  wire len_t      frame_len,
	input  wire octet_t    pay_byte,
	output logic           pay_take,
	output logic           tx_en,
	output octet_t         txd
);

	framer_state_t          state;
	len_t                   cnt;
	len_t                   len_q;
	pkt_kind_t              kind_q;
	logic [23:0]            csum_acc;
	logic [15:0]            ip_csum;
	len_t                   ip_len;
	len_t                   udp_len;
	logic [HDR_LEN*8-1:0]   hdr_bytes;
	logic                   start;
	logic                   crc_init;
	logic                   crc_en;
	crc_t                   crc;

	assign start   = (state == IDLE) && frame_req && !frame_ack;
	assign ip_len  = IP_OVERHEAD + len_q;
	assign udp_len = UDP_OVERHEAD + len_q;

	// Ethernet, IPv4 and UDP headers in wire order, UDP checksum left zero
	assign hdr_bytes = {DST_MAC, SRC_MAC, ETH_TYPE,
		IP_VER_TOS, ip_len, IP_IDEN, IP_FLAG, IP_TTL, IP_PROT, ip_csum,
		IP_SRC, IP_DST,
		UDP_SRC_PORT, UDP_DST_PORT, udp_len, 16'h0000};

	// ---------------------------------------------------------------------
	// Frame sequencing
	// ---------------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state     <= IDLE;
			cnt       <= '0;
			frame_ack <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
			if (state == FCS && cnt == 16'd3) begin
				frame_ack <= 1'b1;
			end else if (!frame_req) begin
				frame_ack <= 1'b0;
			end
			case (state)
				IDLE: begin
					cnt <= '0;
					if (start) begin
						state <= PRE;
					end
				end
				PRE: begin
					if (cnt == len_t'(PREAMBLE_LEN - 1)) begin
						state <= SFD;
						cnt   <= '0;
					end
				end
				SFD: begin
					state <= HDR;
					cnt   <= '0;
				end
				HDR: begin
					if (cnt == len_t'(HDR_LEN - 1)) begin
						state <= KIND;
						cnt   <= '0;
					end
				end
				KIND: begin
					state <= PAYLOAD;
					cnt   <= '0;
				end
				PAYLOAD: begin
					if (cnt == len_q - 1'b1) begin
						state <= FCS;
						cnt   <= '0;
					end
				end
				FCS: begin
					if (cnt == 16'd3) begin
						state <= IFG;
						cnt   <= '0;
					end
				end
				IFG: begin
					if (cnt == len_t'(IFG_CYCLES - 1)) begin
						state <= IDLE;
						cnt   <= '0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Length and kind held for the frame, checksum built during preamble
	always_ff @(posedge fifo_clk) begin
		if (start) begin
			len_q  <= frame_len;
			kind_q <= frame_kind;
		end
		if (state == PRE) begin
			if (cnt == 16'd0) begin
				csum_acc <= {8'd0, IP_VER_TOS} + {8'd0, ip_len} + {8'd0, IP_IDEN}
					+ {8'd0, IP_FLAG} + {8'd0, IP_TTL, IP_PROT}
					+ {8'd0, IP_SRC[31:16]} + {8'd0, IP_SRC[15:0]}
					+ {8'd0, IP_DST[31:16]} + {8'd0, IP_DST[15:0]};
			end else if (cnt == 16'd1 || cnt == 16'd2) begin
				// Two folds absorb the carry of the first
				csum_acc <= {8'd0, csum_acc[15:0]} + {16'd0, csum_acc[23:16]};
			end else if (cnt == 16'd3) begin
				ip_csum <= ~csum_acc[15:0];
			end
		end
	end

	// ---------------------------------------------------------------------
	// GMII output and FCS
	// ---------------------------------------------------------------------
	assign tx_en    = (state != IDLE) && (state != IFG);
	assign pay_take = (state == PAYLOAD);
	assign crc_init = (state == SFD);
	assign crc_en   = (state == HDR) || (state == KIND) || (state == PAYLOAD);

	always_comb begin
		case (state)
			PRE:     txd = PRE_BYTE;
			SFD:     txd = SFD_BYTE;
			HDR:     txd = hdr_bytes[8 * (HDR_LEN - 1 - int'(cnt)) +: 8];
			KIND:    txd = kind_q;
			PAYLOAD: txd = pay_byte;
			FCS:     txd = crc[8 * (3 - int'(cnt[1:0])) +: 8];
			default: txd = 8'h00;
		endcase
	end

	eth_crc32 u_crc (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.init     (crc_init),
		.en       (crc_en),
		.data     (txd),
		.crc      (crc)
	);

endmodule

`default_nettype wire

// ==== hdl/line_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_fifo #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 64
) (
	input  wire                      fifo_clk,
	input  wire                      sys_rst,
	input  wire                      wr,
	input  wire  [WIDTH-1:0]         wdata,
	input  wire                      rd,
	output logic [WIDTH-1:0]         rdata,
	output logic                     full,
	output logic [$clog2(DEPTH):0]   count
);

	logic [WIDTH-1:0]         mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic                     do_wr;
	logic                     do_rd;

	// Writes into a full buffer are lost
	assign do_wr = wr && !full;
	assign do_rd = rd && (count != '0);

	always_ff @(posedge fifo_clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Show-ahead, oldest word always visible
	assign rdata = mem[rd_ptr];
	// Count reaches DEPTH only when the top bit is set
	assign full  = count[$clog2(DEPTH)];

endmodule

`default_nettype wire

// ==== hdl/payload_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module payload_arbiter import udp_tx_pkg::*; (
	input  wire            fifo_clk,
	input  wire            sys_rst,
	input  wire            video_req,
	output logic           video_ack,
	input  wire pkt_kind_t video_kind,
	input  wire len_t      video_len,
	input  wire octet_t    video_byte,
	output logic           video_take,
	input  wire            aux_req,
	output logic           aux_ack,
	input  wire pkt_kind_t aux_kind,
	input  wire len_t      aux_len,
	input  wire octet_t    aux_byte,
	output logic           aux_take,
	output logic           frame_req,
	input  wire            frame_ack,
	output pkt_kind_t      frame_kind,
	output len_t           frame_len,
	output octet_t         pay_byte,
	input  wire            pay_take
);

	arb_state_t state;
	// Last grant, also selects the steered source
	logic       last_aux;
	logic       sel_req;
	logic       active;

	assign sel_req = last_aux ? aux_req : video_req;
	assign active  = (state != ARB_IDLE);

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state    <= ARB_IDLE;
			last_aux <= 1'b1;
		end else begin
			case (state)
				ARB_IDLE: begin
					// Round robin, loser of last time wins a tie
					if (video_req && (!aux_req || last_aux)) begin
						last_aux <= 1'b0;
						state    <= ARB_BUSY;
					end else if (aux_req) begin
						last_aux <= 1'b1;
						state    <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					if (frame_ack) begin
						state <= ARB_RELEASE;
					end
				end
				ARB_RELEASE: begin
					if (!sel_req && !frame_ack) begin
						state <= ARB_IDLE;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	assign frame_req  = active && sel_req;
	assign frame_kind = last_aux ? aux_kind : video_kind;
	assign frame_len  = last_aux ? aux_len : video_len;
	assign pay_byte   = last_aux ? aux_byte : video_byte;

	assign video_ack  = active && !last_aux && frame_ack;
	assign aux_ack    = active && last_aux && frame_ack;
	assign video_take = active && !last_aux && pay_take;
	assign aux_take   = active && last_aux && pay_take;

endmodule

`default_nettype wire

// ==== hdl/udp_tx_pkg.sv ====
`default_nettype none

package udp_tx_pkg;

	// ---------------------------------------------------------------------
	// Data widths
	// ---------------------------------------------------------------------
	typedef logic [7:0]  octet_t;
	typedef logic [15:0] pixel_t;
	typedef logic [23:0] sample_t;
	typedef logic [31:0] crc_t;
	typedef logic [15:0] len_t;
	typedef logic [15:0] line_t;
	typedef logic [7:0]  pkt_kind_t;

	localparam int FIFO_DEPTH = 64;
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH) + 1;
	typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

	// Packet kind byte after the UDP header
	localparam pkt_kind_t KIND_VIDEO = 8'd0;
	localparam pkt_kind_t KIND_AUX   = 8'd1;

	// ---------------------------------------------------------------------
	// Frame constants
	// ---------------------------------------------------------------------
	localparam logic [47:0] SRC_MAC      = 48'h00_23_45_67_89_01;
	localparam logic [47:0] DST_MAC      = 48'h00_23_45_67_89_02;
	localparam logic [15:0] ETH_TYPE     = 16'h0800;
	localparam logic [15:0] IP_VER_TOS   = 16'h4500;
	localparam logic [15:0] IP_IDEN      = 16'h0000;
	localparam logic [15:0] IP_FLAG      = 16'h4000;
	localparam logic [7:0]  IP_TTL       = 8'h40;
	localparam logic [7:0]  IP_PROT      = 8'h11;
	localparam logic [31:0] IP_SRC       = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [31:0] IP_DST       = {8'd192, 8'd168, 8'd0, 8'd2};
	localparam logic [15:0] UDP_SRC_PORT = 16'h3038;
	localparam logic [15:0] UDP_DST_PORT = 16'h3039;

	localparam int     PREAMBLE_LEN = 7;
	localparam octet_t PRE_BYTE     = 8'h55;
	localparam octet_t SFD_BYTE     = 8'hD5;
	localparam int     HDR_LEN      = 42;
	localparam int     IFG_CYCLES   = 12;

	// IPv4 header, UDP header and kind byte ahead of the payload
	localparam len_t IP_OVERHEAD  = 16'd29;
	localparam len_t UDP_OVERHEAD = 16'd9;

	localparam int   VIDEO_PIXELS = 16;
	localparam int   AUX_SAMPLES  = 8;
	// Line number plus Y and chroma per pixel
	localparam len_t VIDEO_LEN    = len_t'(2 + 2 * VIDEO_PIXELS);
	localparam len_t AUX_LEN      = len_t'(3 * AUX_SAMPLES);

	// Reflected IEEE 802.3 polynomial
	localparam crc_t CRC_POLY = 32'hEDB8_8320;

	typedef enum logic [2:0] {
		IDLE, PRE, SFD, HDR, KIND, PAYLOAD, FCS, IFG
	} framer_state_t;

	typedef enum logic [1:0] {
		ARB_IDLE, ARB_BUSY, ARB_RELEASE
	} arb_state_t;

endpackage

`default_nettype wire

// ==== hdl/udp_tx_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module udp_tx_top import udp_tx_pkg::*; (
	input  wire          fifo_clk,
	input  wire          sys_rst,
	input  wire          video_wr,
	input  wire pixel_t  video_data,
	output logic         video_full,
	input  wire          aux_wr,
	input  wire sample_t aux_data,
	output logic         aux_full,
	output logic         tx_en,
	output octet_t       txd
);

	pixel_t    video_rdata;
	fifo_cnt_t video_count;
	logic      video_rd;
	sample_t   aux_rdata;
	fifo_cnt_t aux_count;
	logic      aux_rd;

	// Source side of the handshake
	logic      video_req, video_ack, video_take;
	logic      aux_req, aux_ack, aux_take;
	pkt_kind_t video_kind, aux_kind, frame_kind;
	len_t      video_len, aux_len, frame_len;
	octet_t    video_byte, aux_byte, pay_byte;
	logic      frame_req, frame_ack, pay_take;

	line_fifo #(.WIDTH($bits(pixel_t)), .DEPTH(FIFO_DEPTH)) u_video_fifo (
		.fifo_clk (fifo_clk),   .sys_rst (sys_rst),
		.wr       (video_wr),   .wdata   (video_data),
		.rd       (video_rd),   .rdata   (video_rdata),
		.full     (video_full), .count   (video_count)
	);

	line_fifo #(.WIDTH($bits(sample_t)), .DEPTH(FIFO_DEPTH)) u_aux_fifo (
		.fifo_clk (fifo_clk), .sys_rst (sys_rst),
		.wr       (aux_wr),   .wdata   (aux_data),
		.rd       (aux_rd),   .rdata   (aux_rdata),
		.full     (aux_full), .count   (aux_count)
	);

	video_payload u_video (
		.fifo_clk (fifo_clk), .sys_rst (sys_rst),
		.fifo_rdata (video_rdata), .fifo_count (video_count), .fifo_rd (video_rd),
		.req (video_req), .ack (video_ack), .kind (video_kind),
		.payload_len (video_len), .pay_byte (video_byte), .pay_take (video_take)
	);

	aux_payload u_aux (
		.fifo_clk (fifo_clk), .sys_rst (sys_rst),
		.fifo_rdata (aux_rdata), .fifo_count (aux_count), .fifo_rd (aux_rd),
		.req (aux_req), .ack (aux_ack), .kind (aux_kind),
		.payload_len (aux_len), .pay_byte (aux_byte), .pay_take (aux_take)
	);

	payload_arbiter u_arb (
		.fifo_clk (fifo_clk), .sys_rst (sys_rst),
		.video_req (video_req), .video_ack (video_ack), .video_kind (video_kind),
		.video_len (video_len), .video_byte (video_byte), .video_take (video_take),
		.aux_req (aux_req), .aux_ack (aux_ack), .aux_kind (aux_kind),
		.aux_len (aux_len), .aux_byte (aux_byte), .aux_take (aux_take),
		.frame_req (frame_req), .frame_ack (frame_ack), .frame_kind (frame_kind),
		.frame_len (frame_len), .pay_byte (pay_byte), .pay_take (pay_take)
	);

	gmii_framer u_framer (
		.fifo_clk (fifo_clk), .sys_rst (sys_rst),
		.frame_req (frame_req), .frame_ack (frame_ack), .frame_kind (frame_kind),
		.frame_len (frame_len), .pay_byte (pay_byte), .pay_take (pay_take),
		.tx_en (tx_en), .txd (txd)
	);

endmodule

`default_nettype wire

// ==== hdl/video_payload.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_payload import udp_tx_pkg::*; (
	input  wire            fifo_clk,
	input  wire            sys_rst,
	input  wire pixel_t    fifo_rdata,
	input  wire fifo_cnt_t fifo_count,
	output logic           fifo_rd,
	output logic           req,
	input  wire            ack,
	output pkt_kind_t      kind,
	output len_t           payload_len,
	output octet_t         pay_byte,
	input  wire            pay_take
);

	line_t line_num;
	// Byte index into the payload
	len_t  pos;

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			req      <= 1'b0;
			line_num <= '0;
			pos      <= '0;
		end else if (req && ack) begin
			req      <= 1'b0;
			line_num <= line_num + 1'b1;
			pos      <= '0;
		end else begin
			// Wait for a whole line before asking
			if (!req && !ack && fifo_count >= fifo_cnt_t'(VIDEO_PIXELS)) begin
				req <= 1'b1;
			end
			if (pay_take) begin
				pos <= pos + 1'b1;
			end
		end
	end

	always_comb begin
		if (pos == 16'd0) begin
			pay_byte = line_num[15:8];
		end else if (pos == 16'd1) begin
			pay_byte = line_num[7:0];
		end else if (!pos[0]) begin
			pay_byte = fifo_rdata[15:8];
		end else begin
			pay_byte = fifo_rdata[7:0];
		end
	end

	// Pop once the chroma byte has gone
	assign fifo_rd     = pay_take && (pos > 16'd1) && pos[0];
	assign kind        = KIND_VIDEO;
	assign payload_len = VIDEO_LEN;

endmodule

`default_nettype wire

// ==== verification/udp_tx_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module udp_tx_checker import udp_tx_pkg::*; (
	input wire fifo_clk,
	input wire sys_rst,
	input wire tx_en,
	input wire frame_req,
	input wire frame_ack,
	input wire video_ack,
	input wire aux_ack
);

	a_tx_quiet_in_reset: assert property (@(posedge fifo_clk) sys_rst |=> !tx_en)
		else $error("tx_en high after a reset cycle");

	// Four-phase release order
	a_ack_after_req: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		$fell(frame_ack) |-> !$past(frame_req))
		else $error("frame_ack dropped while frame_req was still high");

	a_one_ack: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		!(video_ack && aux_ack))
		else $error("video and aux acked in the same cycle");

	a_gap: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		$fell(tx_en) |-> (!tx_en) [*IFG_CYCLES])
		else $error("inter-frame gap shorter than IFG_CYCLES");

endmodule

// Framer and arbiter handshake nets as seen in the top level
bind udp_tx_top udp_tx_checker u_checker (
	.fifo_clk  (fifo_clk),
	.sys_rst   (sys_rst),
	.tx_en     (tx_en),
	.frame_req (frame_req),
	.frame_ack (frame_ack),
	.video_ack (video_ack),
	.aux_ack   (aux_ack)
);

`default_nettype wire

// ==== verification/udp_tx_model.svh ====
`ifndef UDP_TX_MODEL_SVH
`define UDP_TX_MODEL_SVH

// ---------------------------------------------------------------------
// Expected frame builder
// ---------------------------------------------------------------------

// Append the low n bytes of v, most significant first
function automatic void put_bytes(input logic [47:0] v, input int n);
	for (int i = n - 1; i >= 0; i--) begin
		exp_frame.push_back(v[8 * i +: 8]);
	end
endfunction

// One's complement of the folded sum over the ten IPv4 header words
function automatic logic [15:0] ip_checksum(input len_t total);
	logic [31:0] sum;
	sum = IP_VER_TOS + total + IP_IDEN + IP_FLAG + {IP_TTL, IP_PROT}
		+ IP_SRC[31:16] + IP_SRC[15:0] + IP_DST[31:16] + IP_DST[15:0];
	while (sum[31:16] != 16'd0) begin
		sum = sum[15:0] + sum[31:16];
	end
	return ~sum[15:0];
endfunction

// Bit serial 802.3 CRC from byte index first to the end, wire byte order
function automatic crc_t fcs_of(input int first);
	logic [31:0] r;
	r = 32'hFFFF_FFFF;
	for (int i = first; i < exp_frame.size(); i++) begin
		for (int b = 0; b < 8; b++) begin
			if (r[0] ^ exp_frame[i][b]) begin
				r = (r >> 1) ^ 32'hEDB8_8320;
			end else begin
				r = r >> 1;
			end
		end
	end
	r = ~r;
	return {r[7:0], r[15:8], r[23:16], r[31:24]};
endfunction

task automatic build_frame(input pkt_kind_t kind);
	len_t    paylen;
	pixel_t  px;
	sample_t s;
	paylen      = (kind == KIND_VIDEO) ? len_t'(2 + 2 * VIDEO_PIXELS) : len_t'(3 * AUX_SAMPLES);
	exp_ip_len  = 16'd29 + paylen;
	exp_udp_len = 16'd9 + paylen;
	exp_frame.delete();
	repeat (PREAMBLE_LEN) put_bytes(48'h55, 1);
	put_bytes(48'hD5, 1);
	put_bytes(DST_MAC, 6);
	put_bytes(SRC_MAC, 6);
	put_bytes(ETH_TYPE, 2);
	put_bytes(IP_VER_TOS, 2);
	put_bytes(exp_ip_len, 2);
	put_bytes(IP_IDEN, 2);
	put_bytes(IP_FLAG, 2);
	put_bytes({IP_TTL, IP_PROT}, 2);
	put_bytes(ip_checksum(exp_ip_len), 2);
	put_bytes(IP_SRC, 4);
	put_bytes(IP_DST, 4);
	put_bytes(UDP_SRC_PORT, 2);
	put_bytes(UDP_DST_PORT, 2);
	put_bytes(exp_udp_len, 2);
	put_bytes(48'h0, 2);
	put_bytes(kind, 1);
	if (kind == KIND_VIDEO) begin
		put_bytes(exp_line, 2);
		exp_line++;
		repeat (VIDEO_PIXELS) begin
			px = video_q.pop_front();
			put_bytes(px, 2);
		end
	end else begin
		repeat (AUX_SAMPLES) begin
			s = aux_q.pop_front();
			put_bytes(s, 3);
		end
	end
	// CRC covers everything after the SFD
	exp_fcs = fcs_of(PREAMBLE_LEN + 1);
	put_bytes(exp_fcs, 4);
endtask

`endif

// ==== verification/udp_tx_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module udp_tx_tb import udp_tx_pkg::*; ();

	logic    fifo_clk;
	logic    sys_rst;
	logic    video_wr;
	pixel_t  video_data;
	logic    video_full;
	logic    aux_wr;
	sample_t aux_data;
	logic    aux_full;
	logic    tx_en;
	octet_t  txd;

	// Model state
	pixel_t    video_q[$];
	sample_t   aux_q[$];
	pkt_kind_t exp_kinds[$];
	octet_t    exp_frame[$];
	crc_t      exp_fcs;
	len_t      exp_ip_len;
	len_t      exp_udp_len;
	line_t     exp_line = '0;

	// Monitor state
	octet_t cap[$];
	logic   in_frame = 1'b0;
	int     gap = 0;
	int     frames_seen = 0;

	string       test_name = "reset";
	int          value_errs = 0;
	int          fault_errs = 0;
	int          cycles = 0;
	logic [15:0] lfsr = 16'd22043;

	// Frame byte offsets of the IPv4 and UDP headers
	int ip_at  = PREAMBLE_LEN + 1 + 14;
	int udp_at = PREAMBLE_LEN + 1 + 34;

	// Eight video and eleven aux frames with gaps, plus write and idle time
	int timeout_cycles = 2 * (
		8 * (PREAMBLE_LEN + 1 + HDR_LEN + 1 + 2 + 2 * VIDEO_PIXELS + 4 + IFG_CYCLES)
		+ 11 * (PREAMBLE_LEN + 1 + HDR_LEN + 1 + 3 * AUX_SAMPLES + 4 + IFG_CYCLES)
		+ 4 * 4 * VIDEO_PIXELS + 2 * (FIFO_DEPTH + 4) + 8 + 20 + 40);

	`include "udp_tx_model.svh"

	udp_tx_top dut (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.video_wr   (video_wr),
		.video_data (video_data),
		.video_full (video_full),
		.aux_wr     (aux_wr),
		.aux_data   (aux_data),
		.aux_full   (aux_full),
		.tx_en      (tx_en),
		.txd        (txd)
	);

	initial begin
		fifo_clk = 1'b0;
		forever #10 fifo_clk = ~fifo_clk;
	end

	always @(posedge fifo_clk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("Timeout after %0d cycles with %0d frames seen", cycles, frames_seen);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ---------------------------------------------------------------------
	// Random numbers and stimulus
	// ---------------------------------------------------------------------
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Video and aux words side by side, random idle cycles before each pair if idle
	// A word counts as stored only while the model FIFO has room
	task automatic write_both(input int nv, input int na, input logic idle);
		logic [31:0] r;
		int          n;
		n = (nv > na) ? nv : na;
		for (int i = 0; i < n; i++) begin
			if (idle) begin
				take_bits(2, r);
				repeat (r[1:0]) @(negedge fifo_clk);
			end
			if (i < nv) begin
				take_bits(16, r);
				check_flag("video full", video_q.size() >= FIFO_DEPTH, video_full);
				video_data = r[15:0];
				video_wr   = 1'b1;
				if (video_q.size() < FIFO_DEPTH) begin
					video_q.push_back(r[15:0]);
				end
			end
			if (i < na) begin
				take_bits(24, r);
				check_flag("aux full", aux_q.size() >= FIFO_DEPTH, aux_full);
				aux_data = r[23:0];
				aux_wr   = 1'b1;
				if (aux_q.size() < FIFO_DEPTH) begin
					aux_q.push_back(r[23:0]);
				end
			end
			@(negedge fifo_clk);
			video_wr = 1'b0;
			aux_wr   = 1'b0;
		end
	endtask

	task automatic wait_frames(input int n);
		while (frames_seen < n) @(negedge fifo_clk);
	endtask

	// ---------------------------------------------------------------------
	// Compare tasks
	// ---------------------------------------------------------------------
	task automatic check_byte(input string what, input octet_t exp, input octet_t got);
		if (got !== exp) begin
			value_errs++;
			$display("ERR %s %s: expected %02h, got %02h", test_name, what, exp, got);
		end
	endtask

	task automatic check_len(input string what, input len_t exp, input len_t got);
		if (got !== exp) begin
			value_errs++;
			$display("ERR %s %s: expected %0d, got %0d", test_name, what, exp, got);
		end
	endtask

	task automatic check_fcs(input string what, input crc_t exp, input crc_t got);
		if (got !== exp) begin
			value_errs++;
			$display("ERR %s %s: expected %08h, got %08h", test_name, what, exp, got);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic got);
		if (got !== exp) begin
			value_errs++;
			$display("ERR %s %s: expected %0b, got %0b", test_name, what, exp, got);
		end
	endtask

	function automatic string field_name(input int i);
		if (i < PREAMBLE_LEN) return "preamble";
		if (i == PREAMBLE_LEN) return "sfd";
		if (i == ip_at + 10 || i == ip_at + 11) return "ip checksum";
		if (i < PREAMBLE_LEN + 1 + HDR_LEN) return "header";
		if (i == PREAMBLE_LEN + 1 + HDR_LEN) return "kind";
		return "payload";
	endfunction

	task automatic check_frame();
		int   n;
		crc_t got_fcs;
		if (exp_kinds.size() == 0) begin
			fault_errs++;
			$display("A frame of %0d bytes was sent with none expected", cap.size());
		end else begin
			build_frame(exp_kinds.pop_front());
			n = exp_frame.size();
			check_len("frame length", len_t'(n), len_t'(cap.size()));
			if (cap.size() == n) begin
				check_len("ip total length", exp_ip_len, {cap[ip_at + 2], cap[ip_at + 3]});
				check_len("udp length", exp_udp_len, {cap[udp_at + 4], cap[udp_at + 5]});
				for (int i = 0; i < n - 4; i++) begin
					check_byte(field_name(i), exp_frame[i], cap[i]);
				end
				got_fcs = {cap[n - 4], cap[n - 3], cap[n - 2], cap[n - 1]};
				check_fcs("fcs", exp_fcs, got_fcs);
			end
		end
	endtask

	// Capture while tx_en is high, checked when it falls
	always @(negedge fifo_clk) begin
		if (sys_rst) begin
			in_frame = 1'b0;
			gap      = 0;
		end else if (tx_en) begin
			if (!in_frame && frames_seen > 0 && gap < IFG_CYCLES) begin
				fault_errs++;
				$display("tx_en rose again after only %0d idle cycles", gap);
			end
			in_frame = 1'b1;
			cap.push_back(txd);
		end else begin
			if (in_frame) begin
				check_frame();
				frames_seen++;
				cap.delete();
				gap = 0;
			end
			in_frame = 1'b0;
			gap++;
		end
	end

	// ---------------------------------------------------------------------
	// Test sequence
	// ---------------------------------------------------------------------
	initial begin
		sys_rst    = 1'b1;
		video_wr   = 1'b0;
		video_data = '0;
		aux_wr     = 1'b0;
		aux_data   = '0;
		repeat (8) @(negedge fifo_clk);
		sys_rst = 1'b0;

		test_name = "idle after reset";
		repeat (20) begin
			@(negedge fifo_clk);
			if (tx_en !== 1'b0) begin
				fault_errs++;
				$display("tx_en went high with both FIFOs empty");
			end
		end

		// Last pixel and last sample land together, so both requests rise at once
		test_name = "video first after reset";
		exp_kinds.push_back(KIND_VIDEO);
		exp_kinds.push_back(KIND_AUX);
		write_both(VIDEO_PIXELS - 1, AUX_SAMPLES - 1, 1'b1);
		write_both(1, 1, 1'b1);
		wait_frames(2);

		// Second video line and both aux packets load while the first video frame runs
		test_name = "alternation";
		exp_kinds.push_back(KIND_VIDEO);
		exp_kinds.push_back(KIND_AUX);
		exp_kinds.push_back(KIND_VIDEO);
		exp_kinds.push_back(KIND_AUX);
		write_both(VIDEO_PIXELS, 0, 1'b1);
		write_both(VIDEO_PIXELS, 2 * AUX_SAMPLES, 1'b1);
		wait_frames(6);

		// Each FIFO fills while the other source holds the framer
		test_name = "fifo full";
		for (int i = 0; i < 5; i++) begin
			exp_kinds.push_back(KIND_VIDEO);
			exp_kinds.push_back(KIND_AUX);
		end
		repeat (3) exp_kinds.push_back(KIND_AUX);
		write_both(VIDEO_PIXELS, 0, 1'b1);
		while (!tx_en) @(negedge fifo_clk);
		write_both(0, FIFO_DEPTH + 4, 1'b0);
		while (tx_en) @(negedge fifo_clk);
		while (!tx_en) @(negedge fifo_clk);
		write_both(FIFO_DEPTH + 4, 0, 1'b0);
		wait_frames(19);

		repeat (40) @(negedge fifo_clk);
		if (frames_seen != 19 || exp_kinds.size() != 0) begin
			fault_errs++;
			$display("Saw %0d frames where 19 were expected", frames_seen);
		end
		if (video_q.size() != 0 || aux_q.size() != 0) begin
			fault_errs++;
			$display("Written words were never sent on GMII");
		end

		$display("Value errors: %0d  Other errors: %0d", value_errs, fault_errs);
		if (value_errs == 0 && fault_errs == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verification
hdl/udp_tx_pkg.sv
hdl/eth_crc32.sv
hdl/line_fifo.sv
hdl/video_payload.sv
hdl/aux_payload.sv
hdl/payload_arbiter.sv
hdl/gmii_framer.sv
hdl/udp_tx_top.sv
verification/udp_tx_checker.sv
verification/udp_tx_tb.sv
